// ==== riscv_params.svh ====
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// data path and address width
`define RISCV_DATA_WIDTH     32

// unified ram, word organised
`define RISCV_MEM_WORDS      256
`define RISCV_MEM_IDX_WIDTH  8

// lsu operation codes
`define RISCV_LSU_OPT_WIDTH  2
`define RISCV_LSU_OPT_NONE   2'd0
`define RISCV_LSU_OPT_LOAD   2'd1
`define RISCV_LSU_OPT_STORE  2'd2

`endif

// ==== riscv_pkg.sv ====
`default_nettype none

`include "riscv_params.svh"

package riscv_pkg;

  // one data word
  typedef logic [`RISCV_DATA_WIDTH-1:0] data_t;

  // byte address, same width as data
  typedef logic [`RISCV_DATA_WIDTH-1:0] addr_t;

  // word index into the ram
  typedef logic [`RISCV_MEM_IDX_WIDTH-1:0] mem_idx_t;

  // one enable per byte lane
  typedef logic [`RISCV_DATA_WIDTH/8-1:0] byte_mask_t;

  typedef logic [`RISCV_LSU_OPT_WIDTH-1:0] lsu_opt_t; // none / load / store

  // access size and sign, as in the instruction
  typedef logic [2:0] funct3_t;

endpackage

`default_nettype wire

// ==== riscv_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one memory channel: request out, grant and read data back
interface riscv_mem_if
  import riscv_pkg::*;
();

  logic       req;
  logic       we;    // write when high, read otherwise
  addr_t      addr;
  data_t      wdata;
  byte_mask_t wmask;
  logic       gnt;   // request taken when req and gnt both high
  data_t      rdata; // valid the cycle after a granted read

  modport requester (
    output req, we, addr, wdata, wmask,
    input  gnt, rdata
  );

  modport responder (
    input  req, we, addr, wdata, wmask,
    output gnt, rdata
  );

endinterface

`default_nettype wire

// ==== riscv_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_params.svh"

module riscv_lsu
  import riscv_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire addr_t    exu_result,
  input  wire data_t    src2,
  input  wire lsu_opt_t lsu_opt,
  input  wire funct3_t  funct3,
  output data_t         lsu_result,
  output logic          lsu_valid,
  riscv_mem_if.requester bus
);

  logic       is_store;
  data_t      st_data;
  byte_mask_t st_mask;
  logic       ld_pend;   // load data arrives this cycle
  funct3_t    ld_funct3;
  logic [1:0] ld_off;    // byte offset of the pending load
  data_t      byte_lane;
  data_t      half_lane;

  assign is_store = (lsu_opt == `RISCV_LSU_OPT_STORE);

  // store lane placement
  always_comb begin
    st_data = src2;
    st_mask = '0;
    case (funct3)
      3'b000: begin // sb
        st_data = src2 << {exu_result[1:0], 3'b000};
        st_mask = 4'b0001 << exu_result[1:0];
      end
      3'b001: begin // sh, bit 0 ignored
        st_data = src2 << {exu_result[1], 4'b0000};
        st_mask = 4'b0011 << {exu_result[1], 1'b0};
      end
      3'b010: st_mask = 4'b1111; // sw
      default: st_mask = '0;     // nothing written
    endcase
  end

  assign bus.req   = (lsu_opt != `RISCV_LSU_OPT_NONE);
  assign bus.we    = is_store;
  assign bus.addr  = exu_result;
  assign bus.wdata = st_data;
  assign bus.wmask = is_store ? st_mask : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      ld_pend <= 1'b0;
    end else begin
      ld_pend <= bus.req && bus.gnt && !bus.we;
    end
  end

  // load attributes, only looked at while ld_pend
  always_ff @(posedge clk) begin
    if (bus.req && !bus.we) begin
      ld_funct3 <= funct3;
      ld_off    <= exu_result[1:0];
    end
  end

  assign byte_lane = bus.rdata >> {ld_off, 3'b000};
  assign half_lane = bus.rdata >> {ld_off[1], 4'b0000};

  always_comb begin
    case (ld_funct3)
      3'b000: lsu_result = {{(`RISCV_DATA_WIDTH-8){byte_lane[7]}}, byte_lane[7:0]};    // lb
      3'b001: lsu_result = {{(`RISCV_DATA_WIDTH-16){half_lane[15]}}, half_lane[15:0]}; // lh
      3'b010: lsu_result = bus.rdata;                                                  // lw
      3'b100: lsu_result = {{(`RISCV_DATA_WIDTH-8){1'b0}}, byte_lane[7:0]};            // lbu
      3'b101: lsu_result = {{(`RISCV_DATA_WIDTH-16){1'b0}}, half_lane[15:0]};          // lhu
      default: lsu_result = '0;
    endcase
  end

  assign lsu_valid = ld_pend;

endmodule

`default_nettype wire

// ==== riscv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_fetch
  import riscv_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  fetch_en,
  input  wire logic  redirect,
  input  wire addr_t redirect_pc,
  output data_t      instr,
  output addr_t      instr_pc,
  output logic       instr_valid,
  riscv_mem_if.requester bus
);

  addr_t pc;
  addr_t pend_pc;  // pc of the read in flight
  logic  pend;
  logic  granted;

  // no fetch in a redirect cycle
  assign bus.req   = fetch_en && !redirect;
  assign bus.we    = 1'b0;
  assign bus.addr  = pc;
  assign bus.wdata = '0;
  assign bus.wmask = '0;

  assign granted = bus.req && bus.gnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= '0;
      pend <= 1'b0;
    end else begin
      pend <= granted;
      if (redirect) begin
        pc <= redirect_pc;
      end else if (granted) begin
        pc <= pc + addr_t'(4);
      end
      // held while the lsu owns the ram
    end
  end

  always_ff @(posedge clk) begin
    if (granted) begin
      pend_pc <= pc;
    end
  end

  assign instr       = bus.rdata;
  assign instr_pc    = pend_pc;
  assign instr_valid = pend;

endmodule

`default_nettype wire

// ==== riscv_mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_mem_arbiter
  import riscv_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  riscv_mem_if.responder lsu_bus,
  riscv_mem_if.responder fetch_bus,
  riscv_mem_if.requester mem_bus
);

  logic sel_lsu;     // lsu wins whenever it asks
  logic lsu_rd;
  logic fetch_rd;
  logic [1:0] owner; // {fetch, lsu} owner of the read now returning

  assign sel_lsu = lsu_bus.req;

  assign lsu_bus.gnt   = lsu_bus.req && mem_bus.gnt;
  assign fetch_bus.gnt = fetch_bus.req && !lsu_bus.req && mem_bus.gnt;

  assign mem_bus.req   = lsu_bus.req || fetch_bus.req;
  assign mem_bus.we    = sel_lsu ? lsu_bus.we    : fetch_bus.we;
  assign mem_bus.addr  = sel_lsu ? lsu_bus.addr  : fetch_bus.addr;
  assign mem_bus.wdata = sel_lsu ? lsu_bus.wdata : fetch_bus.wdata;
  assign mem_bus.wmask = sel_lsu ? lsu_bus.wmask : fetch_bus.wmask;

  // granted reads per port this cycle
  assign lsu_rd   = lsu_bus.gnt && !lsu_bus.we;
  assign fetch_rd = fetch_bus.gnt && !fetch_bus.we;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner <= 2'b00;
    end else begin
      owner <= {fetch_rd, lsu_rd};
    end
  end

  // steer read data back, zero for the other port
  assign lsu_bus.rdata   = owner[0] ? mem_bus.rdata : '0;
  assign fetch_bus.rdata = owner[1] ? mem_bus.rdata : '0;

endmodule

`default_nettype wire

// ==== riscv_dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_params.svh"

module riscv_dmem
  import riscv_pkg::*;
(
  input wire logic clk,
  riscv_mem_if.responder bus
);

  data_t      mem [`RISCV_MEM_WORDS];
  mem_idx_t   idx;
  byte_mask_t wr_en;
  data_t      rdata_q;

  // word index, byte offset bits dropped
  assign idx   = bus.addr[`RISCV_MEM_IDX_WIDTH+1:2];
  assign wr_en = bus.we ? bus.wmask : '0;

  always_ff @(posedge clk) begin
    if (bus.req) begin
      for (int i = 0; i < `RISCV_DATA_WIDTH/8; i++) begin
        if (wr_en[i]) begin
          mem[idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
        end
      end
      rdata_q <= mem[idx]; // old word on a write
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.gnt   = 1'b1; // single cycle, never busy

endmodule

`default_nettype wire

// ==== riscv_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_mem_top
  import riscv_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire lsu_opt_t lsu_opt,
  input  wire funct3_t  funct3,
  input  wire addr_t    exu_result,
  input  wire data_t    src2,
  input  wire logic     fetch_en,
  input  wire logic     redirect,
  input  wire addr_t    redirect_pc,
  output data_t         lsu_result,
  output logic          lsu_valid,
  output data_t         instr,
  output addr_t         instr_pc,
  output logic          instr_valid
);

  riscv_mem_if lsu_bus ();
  riscv_mem_if fetch_bus ();
  riscv_mem_if mem_bus ();  // arbiter to ram

  riscv_lsu i_lsu (
    .clk        (clk),
    .reset      (reset),
    .exu_result (exu_result),
    .src2       (src2),
    .lsu_opt    (lsu_opt),
    .funct3     (funct3),
    .lsu_result (lsu_result),
    .lsu_valid  (lsu_valid),
    .bus        (lsu_bus.requester)
  );

  riscv_fetch i_fetch (
    .clk         (clk),
    .reset       (reset),
    .fetch_en    (fetch_en),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_valid (instr_valid),
    .bus         (fetch_bus.requester)
  );

  riscv_mem_arbiter i_arbiter (
    .clk       (clk),
    .reset     (reset),
    .lsu_bus   (lsu_bus.responder),
    .fetch_bus (fetch_bus.responder),
    .mem_bus   (mem_bus.requester)
  );

  riscv_dmem i_dmem (
    .clk (clk),
    .bus (mem_bus.responder)
  );

endmodule

`default_nettype wire

// ==== riscv_mem_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "riscv_params.svh"

module riscv_mem_top_tb
  import riscv_pkg::*;
();

  localparam int MAX_STEPS = 64;

  logic     clk;
  logic     reset;
  lsu_opt_t lsu_opt;
  funct3_t  funct3;
  addr_t    exu_result;
  data_t    src2;
  logic     fetch_en;
  logic     redirect;
  addr_t    redirect_pc;
  data_t    lsu_result;
  logic     lsu_valid;
  data_t    instr;
  addr_t    instr_pc;
  logic     instr_valid;

  // one entry per step of the test file
  string       op_a [MAX_STEPS];
  string       name_a [MAX_STEPS];
  logic [31:0] f3_a [MAX_STEPS];
  logic [31:0] addr_a [MAX_STEPS];
  logic [31:0] data_a [MAX_STEPS];
  logic [31:0] exp_a [MAX_STEPS];
  int          n_steps = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          value_errs = 0;
  int          valid_errs = 0;
  int          setup_errs = 0;
  addr_t       pc_model;  // pc the next granted fetch reads

  riscv_mem_top i_dut (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: test steps not finished after %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic read_tests();
    int          fd;
    int          cnt;
    string       line;
    string       op;
    string       name;
    logic [31:0] f3, addr, data, exp_v;
    fd = $fopen("riscv_mem_top_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open riscv_mem_top_tests.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) != "#") begin // skip comments and blank lines
        cnt = $sscanf(line, "%s %h %h %h %h %s", op, f3, addr, data, exp_v, name);
        assert (cnt == 6 && n_steps < MAX_STEPS) else begin
          $display("test line not used, malformed or beyond %0d steps: %s", MAX_STEPS, line);
          setup_errs++;
        end
        if (cnt == 6 && n_steps < MAX_STEPS) begin
          op_a[n_steps]   = op;
          f3_a[n_steps]   = f3;
          addr_a[n_steps] = addr;
          data_a[n_steps] = data;
          exp_a[n_steps]  = exp_v;
          name_a[n_steps] = name;
          n_steps++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_step(input int k);
    lsu_opt     = `RISCV_LSU_OPT_NONE;
    funct3      = f3_a[k][2:0];
    exu_result  = addr_a[k];
    src2        = data_a[k];
    redirect    = 1'b0;
    redirect_pc = addr_a[k];
    if (op_a[k] == "store") begin
      lsu_opt = `RISCV_LSU_OPT_STORE;
    end else if (op_a[k] == "load") begin
      lsu_opt = `RISCV_LSU_OPT_LOAD;
    end else if (op_a[k] == "fetch") begin
      fetch_en = 1'b1;
    end else if (op_a[k] == "redirect") begin
      fetch_en = 1'b1;
      redirect = 1'b1;
    end else begin
      fetch_en = 1'b0; // idle ends the fetch stream
    end
  endtask

  // outputs of the cycle after step k
  task automatic check_step(input int k);
    logic want_lsu;
    logic want_instr;
    want_lsu   = (op_a[k] == "load");
    want_instr = (op_a[k] == "fetch");
    assert (lsu_valid === want_lsu) else begin
      if (want_lsu) $display("no lsu_valid pulse for load %s", name_a[k]);
      else $display("lsu_valid pulsed after %s, which issued no load", name_a[k]);
      valid_errs++;
    end
    assert (instr_valid === want_instr) else begin
      if (want_instr) $display("no instr_valid pulse for fetch %s", name_a[k]);
      else $display("instr_valid pulsed after %s, which had no fetch", name_a[k]);
      valid_errs++;
    end
    if (want_lsu && lsu_valid === 1'b1) begin
      assert (lsu_result === exp_a[k]) else begin
        $display("** Error: %s expected %h actual %h", name_a[k], exp_a[k], lsu_result);
        value_errs++;
      end
    end
    if (want_instr) begin
      assert (addr_a[k] === pc_model) else begin
        $display("test file has pc %h for %s, pc model is at %h", addr_a[k], name_a[k], pc_model);
        setup_errs++;
      end
    end
    if (want_instr && instr_valid === 1'b1) begin
      assert (instr_pc === pc_model) else begin
        $display("** Error: %s pc expected %h actual %h", name_a[k], pc_model, instr_pc);
        value_errs++;
      end
      assert (instr === exp_a[k]) else begin
        $display("** Error: %s expected %h actual %h", name_a[k], exp_a[k], instr);
        value_errs++;
      end
    end
  endtask

  // redirect loads the pc, a granted fetch adds 4
  task automatic advance_pc_model(input int k);
    if (op_a[k] == "redirect") pc_model = addr_a[k];
    else if (op_a[k] == "fetch") pc_model = pc_model + 4;
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    lsu_opt     = `RISCV_LSU_OPT_NONE;
    funct3      = '0;
    exu_result  = '0;
    src2        = '0;
    fetch_en    = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    pc_model    = '0;
    read_tests();
    cycle_limit = 4 * n_steps + 100;
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;
    if (n_steps > 0) drive_step(0);
    for (int k = 0; k < n_steps; k++) begin
      @(posedge clk);
      #1;
      check_step(k);
      advance_pc_model(k);
      #1;
      if (k + 1 < n_steps) drive_step(k + 1);
    end
    if (n_steps == 0) begin
      $display("no test steps read from riscv_mem_top_tests.txt");
      setup_errs++;
    end
    $display("errors: %0d value, %0d valid pulse, %0d test setup", value_errs, valid_errs,
             setup_errs);
    if (value_errs + valid_errs + setup_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== riscv_mem_top_tests.txt ====
# op funct3 addr_or_pc store_data expected name, all numbers hex
# store/load drive the lsu, fetch/redirect keep fetch_en high until idle
store 2 00000010 deadbeef 00000000 sw_word
load 2 00000010 00000000 deadbeef lw_word
store 2 00000020 11223344 00000000 sw_base
store 1 00000022 0000c3d2 00000000 sh_upper
load 2 00000020 00000000 c3d23344 lw_after_sh_upper
store 1 00000020 ffff8001 00000000 sh_lower
load 1 00000020 00000000 ffff8001 lh_lower
load 5 00000020 00000000 00008001 lhu_lower
load 1 00000022 00000000 ffffc3d2 lh_upper
load 5 00000023 00000000 0000c3d2 lhu_upper_odd_addr
store 0 00000024 00000081 00000000 sb_lane0
store 0 00000025 ffffff02 00000000 sb_lane1
store 0 00000026 12345683 00000000 sb_lane2
store 0 00000027 00000004 00000000 sb_lane3
load 2 00000024 00000000 04830281 lw_after_sb
load 0 00000024 00000000 ffffff81 lb_lane0
load 4 00000026 00000000 00000083 lbu_lane2
store 3 00000020 ffffffff 00000000 store_funct3_3
load 2 00000020 00000000 c3d28001 lw_after_funct3_3
load 3 00000020 00000000 00000000 load_funct3_3
store 2 00000000 00000013 00000000 sw_prog0
store 2 00000004 00100093 00000000 sw_prog1
store 2 00000008 00200113 00000000 sw_prog2
store 2 0000000c 00308193 00000000 sw_prog3
store 2 00000040 0badf00d 00000000 sw_target
fetch 0 00000000 00000000 00000013 fetch_pc0
fetch 0 00000004 00000000 00100093 fetch_pc4
fetch 0 00000008 00000000 00200113 fetch_pc8
load 2 00000010 00000000 deadbeef arb_load0
load 2 00000020 00000000 c3d28001 arb_load1
load 4 00000024 00000000 00000081 arb_load2
fetch 0 0000000c 00000000 00308193 fetch_resume_pc12
fetch 0 00000010 00000000 deadbeef fetch_pc16
redirect 0 00000040 00000000 00000000 redirect_40
fetch 0 00000040 00000000 0badf00d fetch_after_redirect
idle 0 00000000 00000000 00000000 idle_end

// ==== riscv_mem_top.f ====
+incdir+.
riscv_pkg.sv
riscv_mem_if.sv
riscv_lsu.sv
riscv_fetch.sv
riscv_mem_arbiter.sv
riscv_dmem.sv
riscv_mem_top.sv
riscv_mem_top_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_mem_top

export_include_dirs:
  - .

sources:
  - riscv_pkg.sv
  - riscv_mem_if.sv
  - riscv_lsu.sv
  - riscv_fetch.sv
  - riscv_mem_arbiter.sv
  - riscv_dmem.sv
  - riscv_mem_top.sv
  - target: test
    files:
      - riscv_mem_top_tb.sv
